//--- Makefile
VERILATOR := verilator
TOP       := axi_mem_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
verilog/axi_mem_pkg.sv
verilog/axi_burst_addr.sv
verilog/axi_byte_ram.sv
verilog/axi_mem_ctrl.sv
verilog/axi_mem_top.sv
dv/axi_mem_tb.sv

//--- dv/axi_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_tb
  import axi_mem_pkg::*;
();

  localparam int MEM_BYTES    = 128;
  localparam int MA           = $clog2(MEM_BYTES);
  localparam int RST_CYCLES   = 10;
  localparam int CYC_PER_BEAT = 40;

  typedef struct packed {
    logic        wr;
    logic [3:0]  id;
    logic [31:0] addr;
    logic [3:0]  len;
    logic [2:0]  size;
    logic [3:0]  strb;
    logic        bad_last;  // misplace wlast on beat 0, drop it on the last beat
  } txn_t;

  logic    aclk;
  logic    arstn;
  axi_ax_t ar;
  axi_ax_t aw;
  axi_w_t  w;
  axi_r_t  r;
  axi_b_t  b;
  logic    arvalid, arready, awvalid, awready, wvalid, wready;
  logic    rvalid, rready, bvalid, bready;

  txn_t       tbl[$];
  logic [7:0] model [MEM_BYTES];  // byte-wide reference memory
  integer     seed = 32'h7416_fd44;
  int         cycles = 0;
  int         limit = 0;
  int         beats;

  axi_mem_top #(.MEM_BYTES(MEM_BYTES)) uut (
    .aclk    (aclk),
    .arstn   (arstn),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .r       (r),
    .rvalid  (rvalid),
    .rready  (rready),
    .b       (b),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    assert (cycles <= limit) else abort_run("timeout, the DUT stopped answering");
  end

  task automatic add_txn(input logic wr, input logic [3:0] id, input logic [31:0] addr,
                         input logic [3:0] len, input logic [2:0] size,
                         input logic [3:0] strb, input logic bad_last);
    txn_t t;
    t = '{wr, id, addr, len, size, strb, bad_last};
    tbl.push_back(t);
  endtask

  function automatic logic [31:0] addr_of_beat(input txn_t t, input int k);
    return t.addr + (32'(k) << t.size);
  endfunction

  function automatic logic out_of_range(input txn_t t, input logic [31:0] a);
    return (t.size > 3'd2) || ((33'(a) + (33'd1 << t.size)) > 33'(MEM_BYTES));
  endfunction

  // lanes a[1:0] up to a[1:0]+bytes-1, nothing above lane 3
  function automatic logic [3:0] lanes_of(input txn_t t, input logic [31:0] a);
    logic [3:0] m;
    int         lo;
    int         hi;
    lo = int'(a[1:0]);
    hi = lo + (1 << t.size) - 1;
    for (int i = 0; i < 4; i++) begin
      m[i] = (i >= lo) && (i <= hi);
    end
    return m;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    logic [MA-1:0] base;
    base = {a[MA-1:2], 2'b00};
    return {model[base | MA'(3)], model[base | MA'(2)], model[base | MA'(1)], model[base]};
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [3:0] lanes, input axi_w_t beat);
    logic [MA-1:0] base;
    base = {a[MA-1:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      if (lanes[i] && beat.strb[i]) model[base | MA'(i)] = beat.data[8*i +: 8];
    end
  endtask

  task automatic check_idle();
    assert (arready) else abort_run("mismatch arready: got 0 expected 1");
    assert (awready) else abort_run("mismatch awready: got 0 expected 1");
    assert (!rvalid) else abort_run("mismatch rvalid: got 1 expected 0");
    assert (!wready) else abort_run("mismatch wready: got 1 expected 0");
    assert (!bvalid) else abort_run("mismatch bvalid: got 1 expected 0");
  endtask

  task automatic run_write(input txn_t t);
    axi_w_t      beat;
    axi_b_t      held;
    logic [31:0] a;
    logic [31:0] rnd;
    logic        err;
    logic        stalled;
    logic        done;
    err = t.bad_last;
    assert (awready) else abort_run("awready low at the start of a write");
    aw.id    = t.id;
    aw.addr  = t.addr;
    aw.len   = t.len;
    aw.size  = axi_size_e'(t.size);
    awvalid  = 1'b1;
    @(negedge aclk);  // AW handshake on the edge in between
    awvalid = 1'b0;
    for (int k = 0; k <= int'(t.len); k++) begin
      rnd = $random(seed);
      while (rnd[1:0] == 2'b00) begin  // idle gap on W
        assert (wready) else abort_run("wready dropped during a write burst");
        @(negedge aclk);
        rnd = $random(seed);
      end
      a         = addr_of_beat(t, k);
      beat.data = $random(seed);
      beat.strb = t.strb;
      beat.last = t.bad_last ? (k == 0 && t.len != 4'd0) : (k == int'(t.len));
      w         = beat;
      wvalid    = 1'b1;
      assert (wready) else abort_run("wready low during a write burst");
      if (out_of_range(t, a)) err = 1'b1;
      else model_write(a, lanes_of(t, a), beat);
      @(negedge aclk);
      wvalid = 1'b0;
    end
    assert (!wready) else abort_run("wready still high after the last write beat");
    assert (bvalid) else abort_run("bvalid did not rise after the last write beat");
    stalled = 1'b0;
    done    = 1'b0;
    held    = b;
    while (!done) begin
      assert (bvalid) else abort_run("bvalid dropped before the B handshake");
      if (stalled) begin
        assert (b == held) else abort_run($sformatf("mismatch b: got %h held %h", b, held));
      end
      rnd    = $random(seed);
      bready = rnd[0];
      if (bvalid && bready) begin
        assert (b.id == t.id) else abort_run($sformatf("mismatch b.id: got %h expected %h",
                                                       b.id, t.id));
        assert (b.resp == (err ? resp_slverr : resp_okay))
          else abort_run($sformatf("mismatch b.resp: got %h expected %h", b.resp,
                                   err ? resp_slverr : resp_okay));
        done = 1'b1;
      end
      stalled = bvalid && !bready;
      held    = b;
      @(negedge aclk);
    end
    bready = 1'b0;
    check_idle();  // awready back one cycle after B
  endtask

  task automatic run_read(input txn_t t);
    axi_r_t      exp;
    axi_r_t      held;
    logic [31:0] a;
    logic [31:0] rnd;
    logic        stalled;
    int          k;
    assert (arready) else abort_run("arready low at the start of a read");
    ar.id   = t.id;
    ar.addr = t.addr;
    ar.len  = t.len;
    ar.size = axi_size_e'(t.size);
    arvalid = 1'b1;
    @(negedge aclk);
    arvalid = 1'b0;
    assert (rvalid) else abort_run("rvalid did not rise one cycle after the AR handshake");
    k       = 0;
    stalled = 1'b0;
    held    = r;
    while (k <= int'(t.len)) begin
      // next beat is due right after each handshake
      assert (rvalid) else abort_run("rvalid low in the middle of a read burst");
      if (stalled) begin
        assert (r == held) else abort_run($sformatf("mismatch r: got %h held %h", r, held));
      end
      rnd    = $random(seed);
      rready = rnd[0];
      if (rvalid && rready) begin
        a        = addr_of_beat(t, k);
        exp.id   = t.id;
        exp.last = (k == int'(t.len));
        if (out_of_range(t, a)) begin
          exp.data = '0;
          exp.resp = resp_slverr;
        end else begin
          exp.data = model_word(a);
          exp.resp = resp_okay;
        end
        assert (r.id == exp.id)
          else abort_run($sformatf("mismatch r.id: got %h expected %h", r.id, exp.id));
        assert (r.data == exp.data)
          else abort_run($sformatf("mismatch r.data: got %h expected %h", r.data, exp.data));
        assert (r.resp == exp.resp)
          else abort_run($sformatf("mismatch r.resp: got %h expected %h", r.resp, exp.resp));
        assert (r.last == exp.last)
          else abort_run($sformatf("mismatch r.last: got %h expected %h", r.last, exp.last));
        k++;
      end
      stalled = rvalid && !rready;
      held    = r;
      @(negedge aclk);
    end
    rready = 1'b0;
    check_idle();
  endtask

  initial begin
    arstn   = 1'b0;
    ar      = '0;
    aw      = '0;
    w       = '0;
    arvalid = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b0;
    bready  = 1'b0;

    //      wr    id     addr    len    size  strb   bad_last
    add_txn(1'b1, 4'd1,  32'd0,   4'd15, 3'd2, 4'hf, 1'b0);  // fill lower half
    add_txn(1'b1, 4'd2,  32'd64,  4'd15, 3'd2, 4'hf, 1'b0);  // fill upper half
    add_txn(1'b0, 4'd3,  32'd0,   4'd15, 3'd2, 4'h0, 1'b0);
    add_txn(1'b0, 4'd4,  32'd64,  4'd7,  3'd2, 4'h0, 1'b0);
    add_txn(1'b0, 4'd5,  32'd96,  4'd0,  3'd2, 4'h0, 1'b0);
    add_txn(1'b0, 4'd6,  32'd100, 4'd3,  3'd2, 4'h0, 1'b0);
    add_txn(1'b1, 4'd7,  32'd5,   4'd6,  3'd0, 4'hf, 1'b0);  // byte walk across lanes
    add_txn(1'b1, 4'd8,  32'd18,  4'd3,  3'd1, 4'h6, 1'b0);
    add_txn(1'b1, 4'd9,  32'd33,  4'd2,  3'd1, 4'hf, 1'b0);  // halfword clipped at lane 3
    add_txn(1'b1, 4'd10, 32'd40,  4'd4,  3'd0, 4'ha, 1'b0);
    add_txn(1'b0, 4'd11, 32'd0,   4'd15, 3'd2, 4'h0, 1'b0);
    add_txn(1'b1, 4'd12, 32'd112, 4'd7,  3'd2, 4'hf, 1'b0);  // runs past the end
    add_txn(1'b0, 4'd13, 32'd120, 4'd3,  3'd2, 4'h0, 1'b0);
    add_txn(1'b1, 4'd14, 32'd8,   4'd1,  3'd3, 4'hf, 1'b0);  // 8-byte size
    add_txn(1'b0, 4'd15, 32'd0,   4'd1,  3'd3, 4'h0, 1'b0);
    add_txn(1'b1, 4'd0,  32'd48,  4'd3,  3'd2, 4'hf, 1'b1);
    add_txn(1'b1, 4'd3,  32'd60,  4'd0,  3'd1, 4'hf, 1'b1);  // single beat, no wlast
    add_txn(1'b0, 4'd2,  32'd32,  4'd15, 3'd2, 4'h0, 1'b0);
    add_txn(1'b0, 4'd1,  32'd96,  4'd7,  3'd1, 4'h0, 1'b0);
    add_txn(1'b0, 4'd14, 32'd3,   4'd4,  3'd0, 4'h0, 1'b0);

    beats = 0;
    foreach (tbl[i]) beats += int'(tbl[i].len) + 1;
    limit = CYC_PER_BEAT * beats;

    repeat (RST_CYCLES) begin
      @(negedge aclk);
      check_idle();
    end
    arstn = 1'b1;
    @(negedge aclk);
    check_idle();

    foreach (tbl[i]) begin
      if (tbl[i].wr) run_write(tbl[i]);
      else run_read(tbl[i]);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/axi_burst_addr.sv
`timescale 1ns/10ps
`default_nettype none

module axi_burst_addr
  import axi_mem_pkg::*;
#(
  parameter int MEM_BYTES = 128
) (
  input  wire                   aclk,
  input  wire                   arstn,
  input  wire                   load,     // address handshake
  input  wire axi_ax_t          req,
  input  wire                   advance,  // data handshake before the last beat
  output logic [AXI_ADDR_W-1:0] beat_addr,
  output logic [AXI_STRB_W-1:0] lane_mask,
  output logic                  beat_last,
  output logic                  beat_err,
  output logic [AXI_ID_W-1:0]   id
);

  localparam logic [AXI_ADDR_W:0] MEM_LIMIT = MEM_BYTES;

  axi_ax_t               req_q;
  logic [AXI_ADDR_W-1:0] addr_q;
  logic [3:0]            beat_cnt;
  logic [AXI_ADDR_W-1:0] step;       // bytes per beat
  logic [AXI_STRB_W-1:0] size_mask;
  logic [AXI_ADDR_W:0]   beat_end;   // one past the last byte of this beat
  logic                  size_err;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      beat_cnt <= '0;
    end else if (load) begin
      beat_cnt <= '0;
    end else if (advance) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      req_q  <= req;
      addr_q <= req.addr;
    end else if (advance) begin
      addr_q <= addr_q + step;  // incrementing burst only
    end
  end

  assign step = AXI_ADDR_W'(1) << req_q.size;

  always_comb begin
    case (req_q.size)
      size_1b: size_mask = 4'b0001;
      size_2b: size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  // shift drops lanes past 3
  assign lane_mask = size_mask << addr_q[1:0];

  assign beat_end  = {1'b0, addr_q} + {1'b0, step};
  assign size_err  = req_q.size > size_4b;
  assign beat_err  = size_err || (beat_end > MEM_LIMIT);
  assign beat_last = beat_cnt == req_q.len;
  assign beat_addr = addr_q;
  assign id        = req_q.id;

  // controller must stop stepping once the final beat is reached
  a_cnt_le_len: assert property (@(posedge aclk) disable iff (!arstn)
    advance |-> beat_cnt < req_q.len);

endmodule

`default_nettype wire

//--- verilog/axi_byte_ram.sv
`timescale 1ns/10ps
`default_nettype none

module axi_byte_ram
  import axi_mem_pkg::*;
#(
  parameter int MEM_BYTES = 128
) (
  input  wire                   aclk,
  input  wire                   we,
  input  wire [AXI_ADDR_W-1:0]  wr_addr,
  input  wire [AXI_STRB_W-1:0]  wr_lanes,  // lanes of the current transfer size
  input  wire axi_w_t           wdata,
  input  wire [AXI_ADDR_W-1:0]  rd_addr,
  output logic [AXI_DATA_W-1:0] rd_word
);

  localparam int WORDS = MEM_BYTES / 4;
  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  logic [AXI_DATA_W-1:0] mem [WORDS];
  logic [AXI_STRB_W-1:0] byte_en;
  logic [IDX_W-1:0]      wr_idx;
  logic [IDX_W-1:0]      rd_idx;

  assign wr_idx = wr_addr[IDX_W+1:2];
  assign rd_idx = rd_addr[IDX_W+1:2];

  // a byte is written only where the transfer lane and the strobe agree
  assign byte_en = wr_lanes & wdata.strb;

  always_ff @(posedge aclk) begin
    if (we) begin
      for (int i = 0; i < AXI_STRB_W; i++) begin
        if (byte_en[i]) begin
          mem[wr_idx][8*i +: 8] <= wdata.data[8*i +: 8];
        end
      end
    end
  end

  // a same-cycle write shows up on the read port one cycle later
  assign rd_word = mem[rd_idx];

  // write enable is gated by the range check upstream
  a_we_in_range: assert property (@(posedge aclk)
    we |-> wr_addr < MEM_BYTES);

endmodule

`default_nettype wire

//--- verilog/axi_mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_ctrl
  import axi_mem_pkg::*;
(
  input  wire                  aclk,
  input  wire                  arstn,
  input  wire                  arvalid,
  output logic                 arready,
  input  wire                  awvalid,
  output logic                 awready,
  input  wire axi_w_t          w,
  input  wire                  wvalid,
  output logic                 wready,
  output axi_r_t               r,
  output logic                 rvalid,
  input  wire                  rready,
  output axi_b_t               b,
  output logic                 bvalid,
  input  wire                  bready,
  output logic                 rd_load,
  output logic                 rd_advance,
  input  wire                  rd_last,
  input  wire                  rd_err,
  input  wire [AXI_ID_W-1:0]   rd_id,
  input  wire [AXI_DATA_W-1:0] rd_word,
  output logic                 wr_load,
  output logic                 wr_advance,
  output logic                 ram_we,
  input  wire                  wr_last,
  input  wire                  wr_err,
  input  wire [AXI_ID_W-1:0]   wr_id
);

  rd_state_e rd_state;
  wr_state_e wr_state;

  logic   ar_hs, r_hs, aw_hs, w_hs, b_hs;
  axi_r_t r_beat;    // live beat from the RAM
  axi_r_t r_hold;    // frozen copy while the master stalls
  logic   rd_hold;
  logic   wr_err_q;  // sticky over the burst
  logic   beat_bad;

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;
  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;

  assign arready = rd_state == rd_idle;
  assign rvalid  = rd_state == rd_beat;
  assign awready = wr_state == wr_idle;
  assign wready  = wr_state == wr_beat;
  assign bvalid  = wr_state == wr_resp;

  assign rd_load    = ar_hs;
  assign rd_advance = r_hs && !rd_last;
  assign wr_load    = aw_hs;
  assign wr_advance = w_hs && !wr_last;
  assign ram_we     = w_hs && !wr_err;

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: if (ar_hs) rd_state <= rd_beat;
        rd_beat: if (r_hs && rd_last) rd_state <= rd_idle;
      endcase
    end
  end

  always_comb begin
    r_beat.id   = rd_id;
    r_beat.data = rd_err ? '0 : rd_word;
    r_beat.resp = rd_err ? resp_slverr : resp_okay;
    r_beat.last = rd_last;
  end

  // a write to the same word must not disturb a stalled beat
  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) rd_hold <= 1'b0;
    else        rd_hold <= rvalid && !rready;
  end

  always_ff @(posedge aclk) begin
    if (rvalid && !rready) r_hold <= r;
  end

  assign r = rd_hold ? r_hold : r_beat;

  // wlast is checked against the beat count, not used to end the burst
  assign beat_bad = wr_err || (w.last != wr_last);

  always_ff @(posedge aclk or negedge arstn) begin
    if (!arstn) begin
      wr_state <= wr_idle;
      wr_err_q <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (aw_hs) begin
            wr_state <= wr_beat;
            wr_err_q <= 1'b0;
          end
        end
        wr_beat: begin
          if (w_hs) begin
            wr_err_q <= wr_err_q || beat_bad;
            if (wr_last) wr_state <= wr_resp;
          end
        end
        wr_resp: if (b_hs) wr_state <= wr_idle;
        default: wr_state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (w_hs && wr_last) begin
      b.id   <= wr_id;
      b.resp <= (wr_err_q || beat_bad) ? resp_slverr : resp_okay;
    end
  end

  a_r_stable: assert property (@(posedge aclk) disable iff (!arstn)
    rvalid && !rready |=> rvalid && $stable(r));

  a_b_stable: assert property (@(posedge aclk) disable iff (!arstn)
    bvalid && !bready |=> bvalid && $stable(b));

endmodule

`default_nettype wire

//--- verilog/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // codes above size_4b can arrive on the bus and are flagged as errors
  typedef enum logic [2:0] {
    size_1b = 3'd0,
    size_2b = 3'd1,
    size_4b = 3'd2
  } axi_size_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  // shared by AR and AW
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
    logic [3:0]            len;  // beats minus one
    axi_size_e             size;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  typedef enum logic {rd_idle, rd_beat} rd_state_e;

  typedef enum logic [1:0] {wr_idle, wr_beat, wr_resp} wr_state_e;

endpackage

`default_nettype wire

//--- verilog/axi_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_top
  import axi_mem_pkg::*;
#(
  parameter int MEM_BYTES = 128
) (
  input  wire          aclk,
  input  wire          arstn,
  input  wire axi_ax_t ar,
  input  wire          arvalid,
  output logic         arready,
  input  wire axi_ax_t aw,
  input  wire          awvalid,
  output logic         awready,
  input  wire axi_w_t  w,
  input  wire          wvalid,
  output logic         wready,
  output axi_r_t       r,
  output logic         rvalid,
  input  wire          rready,
  output axi_b_t       b,
  output logic         bvalid,
  input  wire          bready
);

  // read side
  logic                  rd_load, rd_advance, rd_last, rd_err;
  logic [AXI_ID_W-1:0]   rd_id;
  logic [AXI_ADDR_W-1:0] rd_addr;
  logic [AXI_DATA_W-1:0] rd_word;

  // write side
  logic                  wr_load, wr_advance, wr_last, wr_err, ram_we;
  logic [AXI_ID_W-1:0]   wr_id;
  logic [AXI_ADDR_W-1:0] wr_addr;
  logic [AXI_STRB_W-1:0] wr_lanes;

  axi_mem_ctrl u_ctrl (
    .aclk       (aclk),
    .arstn      (arstn),
    .arvalid    (arvalid),
    .arready    (arready),
    .awvalid    (awvalid),
    .awready    (awready),
    .w          (w),
    .wvalid     (wvalid),
    .wready     (wready),
    .r          (r),
    .rvalid     (rvalid),
    .rready     (rready),
    .b          (b),
    .bvalid     (bvalid),
    .bready     (bready),
    .rd_load    (rd_load),
    .rd_advance (rd_advance),
    .rd_last    (rd_last),
    .rd_err     (rd_err),
    .rd_id      (rd_id),
    .rd_word    (rd_word),
    .wr_load    (wr_load),
    .wr_advance (wr_advance),
    .ram_we     (ram_we),
    .wr_last    (wr_last),
    .wr_err     (wr_err),
    .wr_id      (wr_id)
  );

  // reads return the whole word and leave the lane mask open
  axi_burst_addr #(.MEM_BYTES(MEM_BYTES)) u_rd_addr (
    .aclk      (aclk),
    .arstn     (arstn),
    .load      (rd_load),
    .req       (ar),
    .advance   (rd_advance),
    .beat_addr (rd_addr),
    .lane_mask (),
    .beat_last (rd_last),
    .beat_err  (rd_err),
    .id        (rd_id)
  );

  axi_burst_addr #(.MEM_BYTES(MEM_BYTES)) u_wr_addr (
    .aclk      (aclk),
    .arstn     (arstn),
    .load      (wr_load),
    .req       (aw),
    .advance   (wr_advance),
    .beat_addr (wr_addr),
    .lane_mask (wr_lanes),
    .beat_last (wr_last),
    .beat_err  (wr_err),
    .id        (wr_id)
  );

  axi_byte_ram #(.MEM_BYTES(MEM_BYTES)) u_ram (
    .aclk     (aclk),
    .we       (ram_we),
    .wr_addr  (wr_addr),
    .wr_lanes (wr_lanes),
    .wdata    (w),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word)
  );

endmodule

`default_nettype wire
